// ==== dv/aes_host_golden.txt ====
# name key(hex, word 7 first) plaintext ciphertext(hex, word 3 first)
# then idle polls, output-valid polls, access that gets a bus error (0 none), all decimal
basic 00000000000000000000000000000000000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a 0 0 0
slow_idle 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8 3 0 0
slow_out 8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b00000000deadbeef ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870 0 5 0
both_polls ffffffffeeeeeeeeddddddddccccccccbbbbbbbbaaaaaaaa9999999988888888 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d 2 4 0
err_key 00000000000000000000000000000000000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 0123456789abcdef0011223344556677 0 0 9
err_poll 00000000000000000000000000000000000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 0123456789abcdef0011223344556677 2 0 2
err_read 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a 0123456789abcdef0011223344556677 0 1 28

// ==== dv/aes_reg_model.sv ====
`timescale 1ns/10ps
// Wishbone slave model of the cipher peripheral registers
// Random wait states, status bits that set after a given number of polls,
// ciphertext from the stimulus and a bus error on one chosen access
module aes_reg_model #(
  parameter int LogDepth = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  aes_host_pkg::wb_m2s_t wb_i,
  output aes_host_pkg::wb_s2m_t wb_o,
  input  aes_host_pkg::block_t  ct_i,
  input  int                    idle_polls_i,
  input  int                    out_polls_i,
  input  int                    err_at_i
);

  // Write log and counters, inspected by the testbench
  logic [aes_host_pkg::AddrWidth-1:0] wr_adr [LogDepth];
  logic [aes_host_pkg::DataWidth-1:0] wr_dat [LogDepth];
  int wr_cnt;
  int acc_cnt;       // Accesses started, counted from 1
  int st_reads;
  int st_before_wr;  // Status reads seen before the first write

  logic                               busy_q;
  int                                 wait_q;
  logic [aes_host_pkg::DataWidth-1:0] status;
  logic [aes_host_pkg::AddrWidth-1:0] out_off;

  assign out_off = wb_i.adr - aes_host_pkg::DataOutBase;

  // Idle before the job starts, then idle and output valid once processing is over
  always_comb begin
    status = '0;
    if (wr_cnt == 0) begin
      status[aes_host_pkg::StatusIdleBit] = (st_reads >= idle_polls_i);
    end else if (st_reads - st_before_wr >= out_polls_i) begin
      status[aes_host_pkg::StatusIdleBit]     = 1'b1;
      status[aes_host_pkg::StatusOutValidBit] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_o         <= '0;
      busy_q       <= 1'b0;
      wait_q       <= 0;
      wr_cnt       <= 0;
      acc_cnt      <= 0;
      st_reads     <= 0;
      st_before_wr <= 0;
    end else begin
      wb_o.ack <= 1'b0;
      wb_o.err <= 1'b0;
      if (wb_i.cyc && wb_i.stb && !wb_o.ack && !wb_o.err) begin
        if (!busy_q) begin
          busy_q  <= 1'b1;
          wait_q  <= int'($urandom % 4);  // 0 to 3 wait states
          acc_cnt <= acc_cnt + 1;
        end else if (wait_q > 0) begin
          wait_q <= wait_q - 1;
        end else if (acc_cnt == err_at_i) begin
          busy_q   <= 1'b0;
          wb_o.err <= 1'b1;
        end else begin
          busy_q   <= 1'b0;
          wb_o.ack <= 1'b1;
          if (wb_i.we) begin
            if (wr_cnt < LogDepth) begin
              wr_adr[wr_cnt] <= wb_i.adr;
              wr_dat[wr_cnt] <= wb_i.dat;
            end
            if (wr_cnt == 0) st_before_wr <= st_reads;
            wr_cnt <= wr_cnt + 1;
          end else if (wb_i.adr == aes_host_pkg::StatusOffset) begin
            wb_o.dat <= status;
            st_reads <= st_reads + 1;
          end else if (out_off < 8'd16) begin
            wb_o.dat <= ct_i[out_off[3:2]];
          end else begin
            wb_o.dat <= '0;
          end
        end
      end
    end
  end

endmodule

// ==== dv/tb_aes_host.sv ====
`timescale 1ns/10ps
// Testbench for the cipher host sequencer
// Runs one job per golden file line against the register model and checks
// write order, status polls, result, error abort and bus timing
module tb_aes_host;

  localparam int MaxTests  = 16;
  localparam int JobWrites = 24;  // 2 aux ctrl, 2 ctrl, 8 + 8 key, 4 data words

  logic                  clk_i;
  logic                  rst_ni;
  aes_host_pkg::key_t    key;
  aes_host_pkg::block_t  data_in;
  aes_host_pkg::wb_m2s_t wb_m2s;
  aes_host_pkg::wb_s2m_t wb_s2m;
  aes_host_pkg::block_t  data_out;
  logic                  done;
  logic                  error;
  aes_host_pkg::block_t  ct;
  int                    idle_polls;
  int                    out_polls;
  int                    err_at;

  string                g_name [MaxTests];
  aes_host_pkg::key_t   g_key  [MaxTests];
  aes_host_pkg::block_t g_pt   [MaxTests];
  aes_host_pkg::block_t g_ct   [MaxTests];
  int                   g_idle [MaxTests];
  int                   g_out  [MaxTests];
  int                   g_err  [MaxTests];

  int    n_tests;
  int    errors;
  int    limit_cycles;
  string cur_test;
  logic  ack_seen_q;
  logic  hold_q;
  logic [aes_host_pkg::AddrWidth-1:0] adr_q;

  aes_host_top uut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .key_i   (key),
    .data_i  (data_in),
    .wb_o    (wb_m2s),
    .wb_i    (wb_s2m),
    .data_o  (data_out),
    .done_o  (done),
    .error_o (error)
  );

  aes_reg_model reg_model (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_i         (wb_m2s),
    .wb_o         (wb_s2m),
    .ct_i         (ct),
    .idle_polls_i (idle_polls),
    .out_polls_i  (out_polls),
    .err_at_i     (err_at)
  );

  always #2 clk_i = ~clk_i;  // 4 ns period

  task automatic compare(input string what, input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH test %s, %s: expected %0h actual %0h", cur_test, what, exp, act);
    end
  endtask

  // Write number i of a complete job, as {address, data}
  function automatic logic [39:0] job_write(input int i, input int t);
    logic [39:0] w;
    if (i < 2) w = {aes_host_pkg::CtrlAuxOffset, aes_host_pkg::CtrlAuxValue};
    else if (i < 4) w = {aes_host_pkg::CtrlOffset, aes_host_pkg::CtrlJobValue};
    else if (i < 12) w = {aes_host_pkg::KeyShare0Base + 8'((i - 4) * 4), g_key[t][i - 4]};
    else if (i < 20) w = {aes_host_pkg::KeyShare1Base + 8'((i - 12) * 4), 32'h0};
    else w = {aes_host_pkg::DataInBase + 8'((i - 20) * 4), g_pt[t][i - 20]};
    return w;
  endfunction

  task automatic read_golden();
    int                   fd;
    string                line;
    string                name;
    aes_host_pkg::key_t   k;
    aes_host_pkg::block_t p;
    aes_host_pkg::block_t c;
    int                   a;
    int                   b;
    int                   e;
    n_tests = 0;
    fd = $fopen("dv/aes_host_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the golden file dv/aes_host_golden.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#" && n_tests < MaxTests) begin
        if ($sscanf(line, "%s %h %h %h %d %d %d", name, k, p, c, a, b, e) == 7) begin
          g_name[n_tests] = name;
          g_key[n_tests]  = k;
          g_pt[n_tests]   = p;
          g_ct[n_tests]   = c;
          g_idle[n_tests] = a;
          g_out[n_tests]  = b;
          g_err[n_tests]  = e;
          n_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_job(input int t);
    int exp_wr;
    int acc_done;
    int i;
    cur_test = g_name[t];
    @(posedge clk_i);
    rst_ni     <= 1'b0;
    key        <= g_key[t];
    data_in    <= g_pt[t];
    ct         <= g_ct[t];
    idle_polls <= g_idle[t];
    out_polls  <= g_out[t];
    err_at     <= g_err[t];
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    compare("done after reset", 0, done);
    compare("error after reset", 0, error);
    compare("data_o after reset", 0, data_out);
    compare("cyc and stb after reset", 0, {wb_m2s.cyc, wb_m2s.stb});
    while (!done) @(posedge clk_i);
    if (g_err[t] == 0) begin
      exp_wr = JobWrites;
      compare("error", 0, error);
      compare("data_o", g_ct[t], data_out);
      compare("status reads", g_idle[t] + g_out[t] + 2, reg_model.st_reads);
    end else begin
      exp_wr = g_err[t] - g_idle[t] - 2;  // Idle polls come first, then the writes
      if (exp_wr < 0) exp_wr = 0;
      if (exp_wr > JobWrites) exp_wr = JobWrites;
      compare("error", 1, error);
      compare("failing access number", g_err[t], reg_model.acc_cnt);
    end
    compare("write count", exp_wr, reg_model.wr_cnt);
    if (reg_model.wr_cnt > 0) begin
      compare("status reads before first write", g_idle[t] + 1, reg_model.st_before_wr);
    end
    for (i = 0; i < exp_wr && i < reg_model.wr_cnt; i++) begin
      compare($sformatf("write %0d", i), job_write(i, t),
              {reg_model.wr_adr[i], reg_model.wr_dat[i]});
    end
    acc_done = reg_model.acc_cnt;
    repeat (8) @(posedge clk_i);
    compare("accesses after done", acc_done, reg_model.acc_cnt);
  endtask

  // Bus timing seen at the pins
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_seen_q <= 1'b0;
      hold_q     <= 1'b0;
    end else begin
      if (ack_seen_q) begin
        compare("cyc and stb in cycle after ack", 0, {wb_m2s.cyc, wb_m2s.stb});
      end
      if (hold_q) compare("adr across wait state", adr_q, wb_m2s.adr);
      if (wb_m2s.stb) compare("sel during access", 4'hf, wb_m2s.sel);  // Full words only
      ack_seen_q <= wb_s2m.ack;
      hold_q     <= wb_m2s.stb && !wb_s2m.ack && !wb_s2m.err;
      adr_q      <= wb_m2s.adr;
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a job did not finish", limit_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    int t;
    int budget;
    void'($urandom(32'hff79_6672));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    key          = '0;
    data_in      = '0;
    ct           = '0;
    idle_polls   = 0;
    out_polls    = 0;
    err_at       = 0;
    errors       = 0;
    limit_cycles = 0;
    read_golden();
    budget = 0;
    for (t = 0; t < n_tests; t++) begin
      budget += 50 * 6 + (g_idle[t] + g_out[t]) * 6;
    end
    limit_cycles = budget;
    for (t = 0; t < n_tests; t++) begin
      run_job(t);
    end
    $display("Summary: %0d tests run, %0d errors", n_tests, errors);
    if (errors == 0 && n_tests > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_aes_host -o tb_aes_host_sim

./obj_dir/tb_aes_host_sim | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"

// ==== source/aes_host_pkg.sv ====
// Shared definitions for the cipher host sequencer
// Register map and status bits of the cipher peripheral, the control word layout,
// and the structs that carry requests, responses and the Wishbone signals
package aes_host_pkg;

  localparam int DataWidth    = 32;
  localparam int AddrWidth    = 8;
  localparam int BlockWords   = 4;
  localparam int KeyWords     = 8;
  localparam int ShadowWrites = 2;

  localparam int IdxWidth       = $clog2(KeyWords);  // Longest write burst is one key share
  localparam int BlockIdxWidth  = $clog2(BlockWords);
  localparam int ShadowCntWidth = (ShadowWrites > 1) ? $clog2(ShadowWrites) : 1;

  // Register map, byte addresses
  localparam logic [AddrWidth-1:0] KeyShare0Base = 8'h04;  // Eight words
  localparam logic [AddrWidth-1:0] KeyShare1Base = 8'h24;  // Eight words
  localparam logic [AddrWidth-1:0] DataInBase    = 8'h54;
  localparam logic [AddrWidth-1:0] DataOutBase   = 8'h64;
  localparam logic [AddrWidth-1:0] CtrlOffset    = 8'h74;
  localparam logic [AddrWidth-1:0] CtrlAuxOffset = 8'h78;
  localparam logic [AddrWidth-1:0] StatusOffset  = 8'h84;

  localparam int StatusIdleBit     = 0;
  localparam int StatusOutValidBit = 3;

  // Main control register, shadowed
  typedef struct packed {
    logic [19:0] pad;
    logic        sideload;
    logic [2:0]  key_len;
    logic [5:0]  mode;       // One-hot
    logic [1:0]  operation;
  } aes_ctrl_t;

  localparam aes_ctrl_t CtrlJobValue = '{
    pad:       '0,
    sideload:  1'b0,         // Key always comes over the bus
    key_len:   3'b001,       // 128 bit key
    mode:      6'b00_0001,   // ECB
    operation: 2'b01         // Encrypt
  };
  localparam logic [DataWidth-1:0] CtrlAuxValue = '0;

  typedef logic [BlockWords-1:0][DataWidth-1:0] block_t;  // Word 0 in the low bits
  typedef logic [KeyWords-1:0][DataWidth-1:0]   key_t;

  // Sequencer to port
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  // Port to sequencer, one pulse per access
  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [AddrWidth-1:0]   adr;
    logic [DataWidth-1:0]   dat;
    logic [DataWidth/8-1:0] sel;
  } wb_m2s_t;

  typedef struct packed {
    logic                 ack;
    logic                 err;
    logic [DataWidth-1:0] dat;
  } wb_s2m_t;

endpackage

// ==== source/aes_host_seq.sv ====
`timescale 1ns/10ps
// Job sequencer for one ECB encryption on the cipher peripheral
// Orders the register accesses of the job, polls status, collects the
// ciphertext and flags done, or done with error after a bus error
module aes_host_seq (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  aes_host_pkg::key_t     key_i,
  input  aes_host_pkg::block_t   data_i,
  output aes_host_pkg::bus_req_t req_o,
  input  logic                   ready_i,
  input  aes_host_pkg::bus_rsp_t rsp_i,
  output aes_host_pkg::block_t   data_o,
  output logic                   done_o,
  output logic                   error_o
);

  typedef enum logic [3:0] {
    PollIdle,
    WrCtrlAux,
    WrCtrl,
    WrKey0,
    WrKey1,
    WrDataIn,
    PollOut,
    RdDataOut,
    Finish
  } phase_e;

  phase_e phase_q;

  logic [aes_host_pkg::IdxWidth-1:0]       idx_q;       // Word within the current phase
  logic [aes_host_pkg::ShadowCntWidth-1:0] shad_q;      // Writes done to a shadowed register
  logic                                    inflight_q;  // Request taken by the port
  logic                                    err_q;
  aes_host_pkg::block_t                    result_q;

  logic                                     rsp_ok;
  logic                                     last_shadow;
  logic                                     last_key;
  logic                                     last_block;
  logic                                     st_idle;
  logic                                     st_out_valid;
  logic [aes_host_pkg::AddrWidth-1:0]       word_off;
  logic [aes_host_pkg::BlockIdxWidth-1:0]   blk_idx;

  assign rsp_ok       = rsp_i.valid && inflight_q;
  assign blk_idx      = idx_q[aes_host_pkg::BlockIdxWidth-1:0];
  assign word_off     = aes_host_pkg::AddrWidth'({idx_q, 2'b00});  // Byte offset of the word
  assign last_shadow  = (shad_q == aes_host_pkg::ShadowCntWidth'(aes_host_pkg::ShadowWrites - 1));
  assign last_key     = (idx_q == aes_host_pkg::IdxWidth'(aes_host_pkg::KeyWords - 1));
  assign last_block   = (idx_q == aes_host_pkg::IdxWidth'(aes_host_pkg::BlockWords - 1));
  assign st_idle      = rsp_i.rdata[aes_host_pkg::StatusIdleBit];
  assign st_out_valid = rsp_i.rdata[aes_host_pkg::StatusOutValidBit];

  // Access for the current phase, held until its response
  always_comb begin
    req_o = '0;
    unique case (phase_q)
      PollIdle, PollOut: begin
        req_o.valid = 1'b1;
        req_o.addr  = aes_host_pkg::StatusOffset;
      end
      WrCtrlAux: begin
        req_o.valid = 1'b1;
        req_o.we    = 1'b1;
        req_o.addr  = aes_host_pkg::CtrlAuxOffset;
        req_o.wdata = aes_host_pkg::CtrlAuxValue;
      end
      WrCtrl: begin
        req_o.valid = 1'b1;
        req_o.we    = 1'b1;
        req_o.addr  = aes_host_pkg::CtrlOffset;
        req_o.wdata = aes_host_pkg::CtrlJobValue;
      end
      WrKey0: begin
        req_o.valid = 1'b1;
        req_o.we    = 1'b1;
        req_o.addr  = aes_host_pkg::KeyShare0Base + word_off;
        req_o.wdata = key_i[idx_q];
      end
      WrKey1: begin
        req_o.valid = 1'b1;
        req_o.we    = 1'b1;
        req_o.addr  = aes_host_pkg::KeyShare1Base + word_off;
        req_o.wdata = '0;  // Unmasked key, second share is zero
      end
      WrDataIn: begin
        req_o.valid = 1'b1;
        req_o.we    = 1'b1;
        req_o.addr  = aes_host_pkg::DataInBase + word_off;
        req_o.wdata = data_i[blk_idx];
      end
      RdDataOut: begin
        req_o.valid = 1'b1;
        req_o.addr  = aes_host_pkg::DataOutBase + word_off;
      end
      default: req_o = '0;  // Finish, nothing more on the bus
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else if (req_o.valid && ready_i) begin
      inflight_q <= 1'b1;
    end else if (rsp_i.valid) begin
      inflight_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PollIdle;
      idx_q   <= '0;
      shad_q  <= '0;
      err_q   <= 1'b0;
    end else if (rsp_ok) begin
      if (rsp_i.err) begin
        phase_q <= Finish;  // Abort the job on any bus error
        err_q   <= 1'b1;
      end else begin
        unique case (phase_q)
          PollIdle: begin
            if (st_idle) phase_q <= WrCtrlAux;
          end
          WrCtrlAux: begin
            shad_q <= last_shadow ? '0 : shad_q + 1'b1;
            if (last_shadow) phase_q <= WrCtrl;
          end
          WrCtrl: begin
            shad_q <= last_shadow ? '0 : shad_q + 1'b1;
            if (last_shadow) phase_q <= WrKey0;
          end
          WrKey0: begin
            idx_q <= last_key ? '0 : idx_q + 1'b1;
            if (last_key) phase_q <= WrKey1;
          end
          WrKey1: begin
            idx_q <= last_key ? '0 : idx_q + 1'b1;
            if (last_key) phase_q <= WrDataIn;
          end
          WrDataIn: begin
            idx_q <= last_block ? '0 : idx_q + 1'b1;
            if (last_block) phase_q <= PollOut;
          end
          PollOut: begin
            if (st_idle && st_out_valid) phase_q <= RdDataOut;
          end
          RdDataOut: begin
            idx_q <= last_block ? '0 : idx_q + 1'b1;
            if (last_block) phase_q <= Finish;
          end
          Finish: phase_q <= Finish;
          default: phase_q <= Finish;
        endcase
      end
    end
  end

  // Ciphertext, word 0 in the low bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
    end else if (rsp_ok && !rsp_i.err && phase_q == RdDataOut) begin
      result_q[blk_idx] <= rsp_i.rdata;
    end
  end

  assign data_o  = result_q;
  assign done_o  = (phase_q == Finish);
  assign error_o = err_q;

  // Port latches the fields only once, so they must hold through the whole access
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o.valid && !rsp_i.valid |=> $stable(req_o));

  // Nothing is handed to the port once the job is over
  no_req_finish_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    phase_q == Finish |-> !inflight_q);

endmodule

// ==== source/aes_host_top.sv ====
`timescale 1ns/10ps
// Host for one encryption job on the cipher peripheral over Wishbone
// key_i and data_i must hold still from reset release until done_o rises
module aes_host_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  aes_host_pkg::key_t    key_i,
  input  aes_host_pkg::block_t  data_i,
  output aes_host_pkg::wb_m2s_t wb_o,
  input  aes_host_pkg::wb_s2m_t wb_i,
  output aes_host_pkg::block_t  data_o,
  output logic                  done_o,
  output logic                  error_o
);

  aes_host_pkg::bus_req_t bus_req;
  aes_host_pkg::bus_rsp_t bus_rsp;
  logic                   port_ready;

  // Job FSM
  aes_host_seq u_seq (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .key_i   (key_i),
    .data_i  (data_i),
    .req_o   (bus_req),
    .ready_i (port_ready),
    .rsp_i   (bus_rsp),
    .data_o  (data_o),
    .done_o  (done_o),
    .error_o (error_o)
  );

  // One access at a time on the bus
  wb_host_port u_port (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bus_req),
    .ready_o (port_ready),
    .rsp_o   (bus_rsp),
    .wb_o    (wb_o),
    .wb_i    (wb_i)
  );

endmodule

// ==== source/wb_host_port.sv ====
`timescale 1ns/10ps
// Wishbone classic master for single register accesses
// Takes one request while idle, runs one bus cycle and returns the response
// one clock after ack or err, with cyc and stb already low
module wb_host_port (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  aes_host_pkg::bus_req_t req_i,
  output logic                   ready_o,
  output aes_host_pkg::bus_rsp_t rsp_o,
  output aes_host_pkg::wb_m2s_t  wb_o,
  input  aes_host_pkg::wb_s2m_t  wb_i
);

  typedef enum logic [1:0] {
    Idle,
    Strobe,
    Recover
  } port_state_e;

  port_state_e state_q, state_d;

  logic                               we_q;
  logic [aes_host_pkg::AddrWidth-1:0] adr_q;
  logic [aes_host_pkg::DataWidth-1:0] dat_q;
  logic [aes_host_pkg::DataWidth-1:0] rdata_q;
  logic                               err_q;
  logic                               accept;
  logic                               term;

  assign ready_o = (state_q == Idle);
  assign accept  = ready_o && req_i.valid;
  assign term    = (state_q == Strobe) && (wb_i.ack || wb_i.err);  // Terminating cycle

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:    if (accept) state_d = Strobe;
      Strobe:  if (term) state_d = Recover;
      Recover: state_d = Idle;  // Forced gap between accesses
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Access fields and the captured response
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q  <= req_i.we;
      adr_q <= req_i.addr;
      dat_q <= req_i.wdata;
    end
    if (term) begin
      rdata_q <= wb_i.dat;
      err_q   <= wb_i.err;
    end
  end

  assign wb_o.cyc = (state_q == Strobe);
  assign wb_o.stb = (state_q == Strobe);
  assign wb_o.we  = we_q;
  assign wb_o.adr = adr_q;
  assign wb_o.dat = dat_q;
  assign wb_o.sel = '1;  // Full words only

  assign rsp_o.valid = (state_q == Recover);
  assign rsp_o.err   = err_q;
  assign rsp_o.rdata = rdata_q;

  stb_in_cyc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.stb |-> wb_o.cyc);

  // Wait states must not disturb the cycle on the bus
  wb_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.stb && !wb_i.ack && !wb_i.err |=> $stable(wb_o.adr) && $stable(wb_o.dat));

  ack_err_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.cyc |-> !(wb_i.ack && wb_i.err));

endmodule

// ==== verilog.f ====
source/aes_host_pkg.sv
source/wb_host_port.sv
source/aes_host_seq.sv
source/aes_host_top.sv
dv/aes_reg_model.sv
dv/tb_aes_host.sv
